// File: design/alu.sv
`timescale 1ns/1ns

module alu (
  input  logic [isa_pkg::alu_op_w-1:0] op,
  input  logic [core_pkg::xlen-1:0]    a,
  input  logic [core_pkg::xlen-1:0]    b,
  output logic [core_pkg::xlen-1:0]    result
);
  import isa_pkg::*;
  import core_pkg::*;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      // rv64 shift amount is six bits
      alu_sll:  result = a << b[5:0];
      alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
      default:  result = a + b;
    endcase
  end

endmodule

// File: design/core_pkg.sv
package core_pkg;

  localparam int xlen   = 64;
  localparam int inst_w = 32;

  localparam logic [xlen-1:0] reset_pc = 64'h0000_0000_8000_0000;

  // apb side
  localparam int paddr_w = 32;
  localparam int pstrb_w = 8;

  // lsu state codes
  localparam int lsu_st_w = 2;
  localparam logic [lsu_st_w-1:0] lsu_idle   = 2'd0;
  localparam logic [lsu_st_w-1:0] lsu_setup  = 2'd1;
  localparam logic [lsu_st_w-1:0] lsu_access = 2'd2;

endpackage

// File: design/exec_if.sv
`timescale 1ns/1ns

interface exec_if;
  import isa_pkg::*;
  import core_pkg::*;

  logic [alu_op_w-1:0] alu_op;
  logic                opa_pc;
  logic                opb_sel;
  logic [xlen-1:0]     imm;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [4:0]          rd;
  logic                reg_we;
  logic [wb_sel_w-1:0] wb_sel;
  logic                mem_rd;
  logic                mem_wr;
  logic                mem_word;
  logic                is_jal;
  logic                is_jalr;
  logic                is_bne;
  logic                is_ebreak;

  modport idu (
    output alu_op, opa_pc, opb_sel, imm, rs1, rs2, rd, reg_we, wb_sel,
           mem_rd, mem_wr, mem_word, is_jal, is_jalr, is_bne, is_ebreak
  );

  modport exu (
    input alu_op, opa_pc, opb_sel, imm, rs1, rs2, rd, reg_we, wb_sel,
          mem_rd, mem_wr, mem_word, is_jal, is_jalr, is_bne, is_ebreak
  );

endinterface

// File: design/exu.sv
`timescale 1ns/1ns

module exu (
  input  logic                         clk,
  input  logic                         arst_n,
  exec_if.exu                          dec,
  output logic [core_pkg::xlen-1:0]    pc,
  output logic                         halted,
  output logic                         trap_ok,
  output logic [core_pkg::paddr_w-1:0] paddr,
  output logic                         psel,
  output logic                         penable,
  output logic                         pwrite,
  output logic [core_pkg::xlen-1:0]    pwdata,
  output logic [core_pkg::pstrb_w-1:0] pstrb,
  input  logic [core_pkg::xlen-1:0]    prdata,
  input  logic                         pready
);
  import isa_pkg::*;
  import core_pkg::*;

  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic            mem_op;
  logic            lsu_done;
  logic            retire;

  assign opa = dec.opa_pc ? pc : rs1_val;
  assign opb = (dec.opb_sel == opb_imm) ? dec.imm : rs2_val;

  alu u_alu (
    .op     (dec.alu_op),
    .a      (opa),
    .b      (opb),
    .result (alu_res)
  );

  // memory ops hold the instruction until the bus is done
  assign mem_op = dec.mem_rd || dec.mem_wr;
  assign retire = !halted && (!mem_op || lsu_done);

  lsu_apb u_lsu (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (mem_op && !halted),
    .write   (dec.mem_wr),
    .word    (dec.mem_word),
    .addr    (alu_res),
    .wdata   (rs2_val),
    .rdata   (load_data),
    .done    (lsu_done),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

  assign pc_plus4 = pc + 64'd4;

  always_comb begin
    case (dec.wb_sel)
      wb_alu_w: wb_data = {{(xlen-32){alu_res[31]}}, alu_res[31:0]};
      wb_load:  wb_data = load_data;
      wb_pc4:   wb_data = pc_plus4;
      wb_imm:   wb_data = dec.imm;
      default:  wb_data = alu_res;
    endcase
  end

  gpr_file u_gpr (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (dec.reg_we && retire),
    .waddr  (dec.rd),
    .raddr1 (dec.rs1),
    .raddr2 (dec.rs2),
    .wdata  (wb_data),
    .rdata1 (rs1_val),
    .rdata2 (rs2_val)
  );

  always_comb begin
    if (dec.is_jal) begin
      next_pc = alu_res;
    end else if (dec.is_jalr) begin
      next_pc = {alu_res[xlen-1:1], 1'b0};
    end else if (dec.is_bne && alu_res != '0) begin
      // alu is busy with the compare
      next_pc = pc + dec.imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  // pc stays on the ebreak once halted
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= reset_pc;
    end else if (retire && !dec.is_ebreak) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halted  <= 1'b0;
      trap_ok <= 1'b0;
    end else if (!halted && dec.is_ebreak) begin
      halted  <= 1'b1;
      trap_ok <= rs1_val == '0;
    end
  end

endmodule

// File: design/gpr_file.sv
`timescale 1ns/1ns

module gpr_file (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      we,
  input  logic [4:0]                waddr,
  input  logic [4:0]                raddr1,
  input  logic [4:0]                raddr2,
  input  logic [core_pkg::xlen-1:0] wdata,
  output logic [core_pkg::xlen-1:0] rdata1,
  output logic [core_pkg::xlen-1:0] rdata2
);
  import core_pkg::*;

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      // x0 never written so it reads zero
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// File: design/idu.sv
`timescale 1ns/1ns

module idu (
  input  logic [core_pkg::inst_w-1:0] inst,
  exec_if.idu                         dec
);
  import isa_pkg::*;
  import core_pkg::*;

  instr_u ir;

  assign ir = inst;

  // immediate format follows the opcode
  always_comb begin
    case (ir.r_fmt.opcode)
      op_lui, op_auipc:
        dec.imm = {{(xlen-32){ir.u_fmt.imm_31_12[19]}}, ir.u_fmt.imm_31_12, 12'b0};
      op_jal:
        dec.imm = {{(xlen-21){ir.j_fmt.imm_20}}, ir.j_fmt.imm_20, ir.j_fmt.imm_19_12,
                   ir.j_fmt.imm_11, ir.j_fmt.imm_10_1, 1'b0};
      op_branch:
        dec.imm = {{(xlen-13){ir.b_fmt.imm_12}}, ir.b_fmt.imm_12, ir.b_fmt.imm_11,
                   ir.b_fmt.imm_10_5, ir.b_fmt.imm_4_1, 1'b0};
      op_store:
        dec.imm = {{(xlen-12){ir.s_fmt.imm_11_5[6]}}, ir.s_fmt.imm_11_5, ir.s_fmt.imm_4_0};
      default:
        dec.imm = {{(xlen-12){ir.i_fmt.imm_11_0[11]}}, ir.i_fmt.imm_11_0};
    endcase
  end

  always_comb begin
    dec.alu_op    = alu_add;
    dec.opa_pc    = 1'b0;
    dec.opb_sel   = opb_imm;
    dec.rs1       = ir.r_fmt.rs1;
    dec.rs2       = ir.r_fmt.rs2;
    dec.rd        = ir.r_fmt.rd;
    dec.reg_we    = 1'b0;
    dec.wb_sel    = wb_alu;
    dec.mem_rd    = 1'b0;
    dec.mem_wr    = 1'b0;
    dec.mem_word  = ir.r_fmt.funct3 == f3_word;
    dec.is_jal    = 1'b0;
    dec.is_jalr   = 1'b0;
    dec.is_bne    = 1'b0;
    dec.is_ebreak = 1'b0;

    case (ir.r_fmt.opcode)
      op_lui: begin
        dec.reg_we = 1'b1;
        dec.wb_sel = wb_imm;
      end
      op_auipc: begin
        dec.opa_pc = 1'b1;
        dec.reg_we = 1'b1;
      end
      op_jal: begin
        dec.opa_pc = 1'b1;
        dec.reg_we = 1'b1;
        dec.wb_sel = wb_pc4;
        dec.is_jal = 1'b1;
      end
      op_jalr: begin
        dec.reg_we  = 1'b1;
        dec.wb_sel  = wb_pc4;
        dec.is_jalr = 1'b1;
      end
      op_branch: begin
        dec.alu_op  = alu_sub;
        dec.opb_sel = opb_rs2;
        dec.is_bne  = ir.b_fmt.funct3 == f3_bne;
      end
      op_load: begin
        if (ir.i_fmt.funct3 == f3_word || ir.i_fmt.funct3 == f3_dword) begin
          dec.reg_we = 1'b1;
          dec.wb_sel = wb_load;
          dec.mem_rd = 1'b1;
        end
      end
      op_store: begin
        dec.mem_wr = ir.s_fmt.funct3 == f3_word || ir.s_fmt.funct3 == f3_dword;
      end
      op_imm: begin
        dec.reg_we = ir.i_fmt.funct3 == f3_add || ir.i_fmt.funct3 == f3_sll
                     || ir.i_fmt.funct3 == f3_sltu;
        if (ir.i_fmt.funct3 == f3_sll) dec.alu_op = alu_sll;
        else if (ir.i_fmt.funct3 == f3_sltu) dec.alu_op = alu_sltu;
      end
      op_imm32: begin
        dec.reg_we = ir.i_fmt.funct3 == f3_add;
        dec.wb_sel = wb_alu_w;
      end
      op_reg, op_reg32: begin
        dec.opb_sel = opb_rs2;
        dec.reg_we  = ir.r_fmt.funct3 == f3_add;
        if (ir.r_fmt.opcode == op_reg32) dec.wb_sel = wb_alu_w;
        if (ir.r_fmt.funct7 == f7_sub && ir.r_fmt.opcode == op_reg) dec.alu_op = alu_sub;
      end
      op_system: begin
        // a0 comes out on the rs1 port for the halt check
        if (ir.i_fmt.imm_11_0 == imm_ebreak && ir.i_fmt.funct3 == 3'b000) begin
          dec.is_ebreak = 1'b1;
          dec.rs1       = reg_a0;
        end
      end
      default: begin
        dec.reg_we = 1'b0;
      end
    endcase
  end

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm32  = 7'b0011011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_reg32  = 7'b0111011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add   = 3'b000;
  localparam logic [2:0] f3_sll   = 3'b001;
  localparam logic [2:0] f3_sltu  = 3'b011;
  localparam logic [2:0] f3_word  = 3'b010;
  localparam logic [2:0] f3_dword = 3'b011;
  localparam logic [2:0] f3_bne   = 3'b001;

  localparam logic [6:0] f7_sub = 7'b0100000;

  // ebreak is the system opcode with imm 1
  localparam logic [11:0] imm_ebreak = 12'h001;
  localparam logic [4:0]  reg_a0     = 5'd10;

  localparam int alu_op_w = 2;
  localparam logic [alu_op_w-1:0] alu_add  = 2'd0;
  localparam logic [alu_op_w-1:0] alu_sub  = 2'd1;
  localparam logic [alu_op_w-1:0] alu_sll  = 2'd2;
  localparam logic [alu_op_w-1:0] alu_sltu = 2'd3;

  localparam logic opb_rs2 = 1'b0;
  localparam logic opb_imm = 1'b1;

  localparam int wb_sel_w = 3;
  localparam logic [wb_sel_w-1:0] wb_alu   = 3'd0;
  localparam logic [wb_sel_w-1:0] wb_alu_w = 3'd1;
  localparam logic [wb_sel_w-1:0] wb_load  = 3'd2;
  localparam logic [wb_sel_w-1:0] wb_pc4   = 3'd3;
  localparam logic [wb_sel_w-1:0] wb_imm   = 3'd4;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r_fmt;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s_fmt;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_fmt;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u_fmt;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_fmt;
  } instr_u;

endpackage

// File: design/lsu_apb.sv
`timescale 1ns/1ns

module lsu_apb (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         req,
  input  logic                         write,
  input  logic                         word,
  input  logic [core_pkg::xlen-1:0]    addr,
  input  logic [core_pkg::xlen-1:0]    wdata,
  output logic [core_pkg::xlen-1:0]    rdata,
  output logic                         done,
  output logic [core_pkg::paddr_w-1:0] paddr,
  output logic                         psel,
  output logic                         penable,
  output logic                         pwrite,
  output logic [core_pkg::xlen-1:0]    pwdata,
  output logic [core_pkg::pstrb_w-1:0] pstrb,
  input  logic [core_pkg::xlen-1:0]    prdata,
  input  logic                         pready
);
  import core_pkg::*;

  logic [lsu_st_w-1:0] state;
  logic                word_q;
  logic                hi_q;
  logic [31:0]         load_half;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= lsu_idle;
      pwrite <= 1'b0;
    end else begin
      case (state)
        lsu_idle: begin
          if (req) begin
            state  <= lsu_setup;
            pwrite <= write;
          end
        end
        lsu_setup:  state <= lsu_access;
        lsu_access: if (pready) state <= lsu_idle;
        default:    state <= lsu_idle;
      endcase
    end
  end

  // bus payload held from setup through the access
  always_ff @(posedge clk) begin
    if (state == lsu_idle && req) begin
      paddr  <= addr[paddr_w-1:0];
      word_q <= word;
      hi_q   <= addr[2];
      pwdata <= word ? {2{wdata[31:0]}} : wdata;
      if (!write) begin
        pstrb <= '0;
      end else if (!word) begin
        pstrb <= '1;
      end else if (addr[2]) begin
        pstrb <= {{(pstrb_w/2){1'b1}}, {(pstrb_w/2){1'b0}}};
      end else begin
        pstrb <= {{(pstrb_w/2){1'b0}}, {(pstrb_w/2){1'b1}}};
      end
    end
  end

  assign psel    = state != lsu_idle;
  assign penable = state == lsu_access;
  assign done    = penable && pready;

  // lw picks a half and sign-extends it
  assign load_half = hi_q ? prdata[63:32] : prdata[31:0];
  assign rdata     = word_q ? {{(xlen-32){load_half[31]}}, load_half} : prdata;

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ns

module rv_core (
  input  logic                         clk,
  input  logic                         arst_n,
  output logic [core_pkg::xlen-1:0]    inst_addr,
  input  logic [core_pkg::inst_w-1:0]  inst,
  output logic [core_pkg::paddr_w-1:0] paddr,
  output logic                         psel,
  output logic                         penable,
  output logic                         pwrite,
  output logic [core_pkg::xlen-1:0]    pwdata,
  output logic [core_pkg::pstrb_w-1:0] pstrb,
  input  logic [core_pkg::xlen-1:0]    prdata,
  input  logic                         pready,
  output logic                         halted,
  output logic                         trap_ok
);

  exec_if dec_bus ();

  idu u_idu (
    .inst (inst),
    .dec  (dec_bus)
  );

  exu u_exu (
    .clk     (clk),
    .arst_n  (arst_n),
    .dec     (dec_bus),
    .pc      (inst_addr),
    .halted  (halted),
    .trap_ok (trap_ok),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

// File: src.f
design/isa_pkg.sv
design/core_pkg.sv
design/exec_if.sv
design/idu.sv
design/alu.sv
design/gpr_file.sv
design/lsu_apb.sv
design/exu.sv
design/rv_core.sv
tb/tb_clk_gen.sv
tb/tb_apb_mem.sv
tb/rv_core_tb.sv

// File: tb/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb;

  localparam logic [63:0] base_pc     = 64'h0000_0000_8000_0000;
  localparam logic [31:0] data_base   = 32'h0000_0400;
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  // longest run is the branch loop test with 29 instructions
  localparam int max_insts      = 29;
  localparam int timeout_cycles = max_insts * 6 + 100;

  logic        clk;
  logic        arst_n;
  logic [63:0] inst_addr;
  logic [31:0] inst;
  logic [31:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [63:0] pwdata;
  logic [7:0]  pstrb;
  logic [63:0] prdata;
  logic        pready;
  logic        halted;
  logic        trap_ok;
  logic        proto_err;

  logic [31:0] rom [64];
  int          prog_len;
  int          prog_gen;

  tb_clk_gen u_clk (
    .clk (clk)
  );

  tb_apb_mem u_mem (
    .clk       (clk),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .prdata    (prdata),
    .pready    (pready),
    .proto_err (proto_err)
  );

  rv_core UUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .inst_addr (inst_addr),
    .inst      (inst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .prdata    (prdata),
    .pready    (pready),
    .halted    (halted),
    .trap_ok   (trap_ok)
  );

  function automatic logic [31:0] itype(logic [6:0] op, logic [2:0] f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic logic [31:0] rtype(logic [6:0] f7, logic [6:0] op, int rd, int rs1, int rs2);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], op};
  endfunction

  function automatic logic [31:0] stype(logic [2:0] f3, int rs2, int rs1, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] addi(int rd, int rs1, int imm);
    return itype(7'h13, 3'd0, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] slli(int rd, int rs1, int shamt);
    return itype(7'h13, 3'd1, rd, rs1, shamt);
  endfunction

  function automatic logic [31:0] sltiu(int rd, int rs1, int imm);
    return itype(7'h13, 3'd3, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] addiw(int rd, int rs1, int imm);
    return itype(7'h1b, 3'd0, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] lw(int rd, int rs1, int imm);
    return itype(7'h03, 3'd2, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] ld(int rd, int rs1, int imm);
    return itype(7'h03, 3'd3, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] jalr(int rd, int rs1, int imm);
    return itype(7'h67, 3'd0, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] add(int rd, int rs1, int rs2);
    return rtype(7'h00, 7'h33, rd, rs1, rs2);
  endfunction

  function automatic logic [31:0] sub(int rd, int rs1, int rs2);
    return rtype(7'h20, 7'h33, rd, rs1, rs2);
  endfunction

  function automatic logic [31:0] addw(int rd, int rs1, int rs2);
    return rtype(7'h00, 7'h3b, rd, rs1, rs2);
  endfunction

  function automatic logic [31:0] sw(int rs2, int rs1, int imm);
    return stype(3'd2, rs2, rs1, imm);
  endfunction

  function automatic logic [31:0] sd(int rs2, int rs1, int imm);
    return stype(3'd3, rs2, rs1, imm);
  endfunction

  function automatic logic [31:0] lui(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] auipc(int rd, int imm20);
    return {imm20[19:0], rd[4:0], 7'h17};
  endfunction

  function automatic logic [31:0] jal(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] bne(int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [63:0] sext32(logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // past the program the core sees ebreak
  function automatic logic [31:0] fetch(logic [63:0] addr);
    logic [63:0] idx;
    idx = (addr - base_pc) >> 2;
    if (addr >= base_pc && idx < prog_len) return rom[idx];
    return ebreak_word;
  endfunction

  always @(inst_addr or prog_gen) begin
    inst = fetch(inst_addr);
  end

  always @(posedge proto_err) begin
    $display("*** FAILED ***");
    $fatal(1);
  end

  task emit(input logic [31:0] word);
    rom[prog_len] = word;
    prog_len++;
  endtask

  task check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task check_mem(input logic [31:0] addr, input logic [63:0] exp, input string what);
    logic [63:0] got;
    u_mem.peek(addr, got);
    check(got, exp, what);
  endtask

  task wait_halt;
    int cycles;
    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) begin
        $display("Timeout: core did not halt within %0d cycles", timeout_cycles);
        $display("*** FAILED ***");
        $fatal(1);
      end
    end
  endtask

  task run_program;
    prog_gen++;
    @(posedge clk);
    #1 arst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 arst_n = 1'b1;
    wait_halt();
  endtask

  task test_arith;
    logic [63:0] a;
    logic [63:0] b;
    a = 64'd100;
    b = -64'd7;
    prog_len = 0;
    emit(addi(5, 0, 100));
    emit(addi(6, 0, -7));
    emit(add(7, 5, 6));
    emit(sub(9, 6, 5));
    emit(slli(11, 6, 33));
    emit(sltiu(12, 5, 101));
    emit(sltiu(13, 6, 5));
    emit(lui(14, 'h80001));
    // auipc is word 8 so its pc is base + 32
    emit(auipc(15, 'h00012));
    emit(addi(8, 0, 'h400));
    emit(sd(7, 8, 0));
    emit(sd(9, 8, 8));
    emit(sd(11, 8, 16));
    emit(sd(12, 8, 24));
    emit(sd(13, 8, 32));
    emit(sd(14, 8, 40));
    emit(sd(15, 8, 48));
    run_program();
    check_mem(data_base, a + b, "add");
    check_mem(data_base + 8, b - a, "sub");
    check_mem(data_base + 16, b << 33, "slli");
    check_mem(data_base + 24, {63'd0, a < 64'd101}, "sltiu small");
    check_mem(data_base + 32, {63'd0, b < 64'd5}, "sltiu unsigned");
    check_mem(data_base + 40, sext32({20'h80001, 12'h000}), "lui");
    check_mem(data_base + 48, base_pc + 32 + sext32({20'h00012, 12'h000}), "auipc");
  endtask

  task test_word;
    logic [63:0] x7;
    logic [63:0] sum;
    u_mem.preload(data_base, 64'h1234_5678_8765_4321);
    u_mem.preload(data_base + 64, 64'haaaa_aaaa_bbbb_bbbb);
    u_mem.preload(data_base + 72, 64'hcccc_cccc_dddd_dddd);
    prog_len = 0;
    emit(addi(8, 0, 'h400));
    emit(lw(5, 8, 0));
    emit(lw(6, 8, 4));
    emit(lui(7, 'h80000));
    emit(addiw(7, 7, -1));
    emit(addiw(9, 7, 1));
    emit(addw(11, 7, 7));
    emit(add(12, 7, 7));
    emit(sd(5, 8, 8));
    emit(sd(6, 8, 16));
    emit(sd(9, 8, 24));
    emit(sd(11, 8, 32));
    emit(sd(12, 8, 40));
    emit(sd(7, 8, 48));
    emit(sw(6, 8, 'h44));
    emit(sw(5, 8, 'h48));
    run_program();
    sum = sext32(32'h8000_0000) + 64'hffff_ffff_ffff_ffff;
    x7 = sext32(sum[31:0]);
    check_mem(data_base + 8, sext32(32'h8765_4321), "lw low half");
    check_mem(data_base + 16, sext32(32'h1234_5678), "lw high half");
    check_mem(data_base + 48, x7, "addiw wrap");
    sum = x7 + 64'd1;
    check_mem(data_base + 24, sext32(sum[31:0]), "addiw");
    sum = x7 + x7;
    check_mem(data_base + 32, sext32(sum[31:0]), "addw");
    check_mem(data_base + 40, sum, "add 64-bit");
    check_mem(data_base + 64, 64'h1234_5678_bbbb_bbbb, "sw high half");
    check_mem(data_base + 72, 64'hcccc_cccc_8765_4321, "sw low half");
  endtask

  task test_flow;
    u_mem.preload(data_base, 64'd5);
    prog_len = 0;
    emit(addi(8, 0, 'h400));
    emit(ld(5, 8, 0));
    emit(addi(6, 0, 0));
    // loop body at word 3
    emit(addi(5, 5, -1));
    emit(addi(6, 6, 1));
    emit(bne(5, 0, -8));
    emit(sd(6, 8, 8));
    emit(sd(5, 8, 16));
    emit(jal(1, 12));
    emit(addi(6, 0, 111));
    emit(addi(6, 0, 222));
    emit(sd(1, 8, 24));
    emit(auipc(7, 0));
    emit(jalr(9, 7, 13));
    emit(addi(6, 0, 333));
    emit(auipc(12, 0));
    emit(sd(12, 8, 32));
    emit(sd(9, 8, 40));
    emit(sd(6, 8, 48));
    run_program();
    check_mem(data_base + 8, 64'd5, "loop count");
    check_mem(data_base + 16, 64'd0, "loop counter end");
    check_mem(data_base + 24, base_pc + 8 * 4 + 4, "jal link");
    check_mem(data_base + 32, (base_pc + 12 * 4 + 13) & ~64'd1, "jalr target");
    check_mem(data_base + 40, base_pc + 13 * 4 + 4, "jalr link");
    check_mem(data_base + 48, 64'd5, "skipped instructions");
  endtask

  task test_x0;
    u_mem.preload(data_base, 64'hffff_0000_ffff_0000);
    prog_len = 0;
    emit(addi(0, 0, 55));
    emit(addi(5, 0, 9));
    emit(add(0, 5, 5));
    emit(lui(0, 'h12345));
    emit(add(7, 0, 5));
    emit(addi(8, 0, 'h400));
    emit(sd(0, 8, 0));
    emit(sd(7, 8, 8));
    run_program();
    check_mem(data_base, 64'd0, "sd of x0");
    check_mem(data_base + 8, 64'd9, "x0 read as zero");
  endtask

  task halt_case(input int a0_val);
    logic [63:0] pc_at_halt;
    prog_len = 0;
    emit(addi(10, 0, a0_val));
    emit(ebreak_word);
    // never reached
    emit(sd(10, 0, 'h400));
    run_program();
    check(trap_ok, a0_val == 0, "trap_ok");
    // ebreak is word 1
    pc_at_halt = base_pc + 64'd4;
    repeat (20) begin
      @(negedge clk);
      check(inst_addr, pc_at_halt, "pc after halt");
      check(psel, 1'b0, "psel after halt");
    end
  endtask

  initial begin
    void'($urandom(93));
    arst_n    = 1'b0;
    inst      = ebreak_word;
    prog_len  = 0;
    prog_gen  = 0;
    test_arith();
    test_word();
    test_flow();
    test_x0();
    halt_case(0);
    halt_case(3);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: tb/tb_apb_mem.sv
`timescale 1ns/1ns

module tb_apb_mem (
  input  logic        clk,
  input  logic [31:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [63:0] pwdata,
  input  logic [7:0]  pstrb,
  output logic [63:0] prdata,
  output logic        pready,
  output logic        proto_err
);

  logic [63:0] mem [256];
  int          wait_left;
  logic        prev_sel;
  logic        prev_en;
  logic        prev_rdy;
  logic [31:0] prev_addr;
  logic        prev_write;
  logic [63:0] prev_wdata;
  logic [7:0]  prev_strb;

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'h0bad_0000 + i, 32'hf00d_0000 + i};
    end
    prdata    = '0;
    pready    = 1'b0;
    proto_err = 1'b0;
    wait_left = 0;
    prev_sel  = 1'b0;
    prev_en   = 1'b0;
    prev_rdy  = 1'b0;
  end

  task preload(input logic [31:0] addr, input logic [63:0] data);
    mem[addr[10:3]] = data;
  endtask

  task peek(input logic [31:0] addr, output logic [63:0] data);
    data = mem[addr[10:3]];
  endtask

  task protocol_error(input string what);
    $display("APB protocol error at %0t: %s", $time, what);
    proto_err = 1'b1;
  endtask

  // slave response with 0 to 3 wait cycles per transfer
  always @(posedge clk) begin
    #1;
    pready = 1'b0;
    if (psel && !penable) begin
      wait_left = $urandom_range(3, 0);
    end else if (psel && penable) begin
      if (wait_left == 0) begin
        pready = 1'b1;
        prdata = mem[paddr[10:3]];
      end else begin
        wait_left--;
      end
    end
  end

  // bus is stable mid-cycle
  always @(negedge clk) begin
    if (penable && !prev_en && !(prev_sel && psel)) begin
      protocol_error("penable rose without a setup cycle");
    end
    if (psel && penable && prev_sel && !(prev_en && prev_rdy) &&
        {paddr, pwrite, pwdata, pstrb} !== {prev_addr, prev_write, prev_wdata, prev_strb}) begin
      protocol_error("address, direction, write data or strobes changed during an access");
    end
    if (!psel && prev_sel && !(prev_en && prev_rdy)) begin
      protocol_error("psel dropped before pready");
    end
    // write lands at the edge that ends the transfer
    if (psel && penable && pready && pwrite) begin
      for (int b = 0; b < 8; b++) begin
        if (pstrb[b]) mem[paddr[10:3]][8*b +: 8] = pwdata[8*b +: 8];
      end
    end
    prev_sel   = psel;
    prev_en    = penable;
    prev_rdy   = pready;
    prev_addr  = paddr;
    prev_write = pwrite;
    prev_wdata = pwdata;
    prev_strb  = pstrb;
  end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule
